/* branch_unit.sv */
/*
 * Branch decision, jump target and branch prediction rollback
 */

`timescale 1ns/1ps
`default_nettype none

module branch_unit #(
    parameter bit BRANCH_PREDICT = 1'b1
) (
    input  exec_pkg::exec_op_e          op_i,
    input  logic                        equal_i,
    input  logic                        less_i,
    input  logic                        less_unsigned_i,
    input  logic                        bp_taken_i,
    input  logic [exec_pkg::XLEN-1:0]   sum_i,
    input  logic [exec_pkg::XLEN-1:0]   pc_sum_i,
    output logic                        jump_o,
    output logic                        jump_rollback_o,
    output logic [exec_pkg::XLEN-1:0]   jump_target_o
);

    import exec_pkg::*;

    logic taken;

    // Condition per operation, jumps always taken
    always_comb begin
        unique case (op_i)
            BEQ:       taken = equal_i;
            BNE:       taken = !equal_i;
            BLT:       taken = less_i;
            BLTU:      taken = less_unsigned_i;
            BGE:       taken = !less_i;
            BGEU:      taken = !less_unsigned_i;
            JAL, JALR: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    // JALR target has bit 0 cleared
    always_comb begin
        unique case (op_i)
            JALR:    jump_target_o = {sum_i[XLEN-1:1], 1'b0};
            JAL:     jump_target_o = sum_i;
            default: jump_target_o = pc_sum_i;
        endcase
    end

    ////////////////////////////////////////
    // Prediction correction
    ////////////////////////////////////////

    // Fetch already followed a predicted-taken branch
    assign jump_o          = taken && !(BRANCH_PREDICT && bp_taken_i);
    // Predicted taken but not taken, go back to the fall-through path
    assign jump_rollback_o = BRANCH_PREDICT && !taken && bp_taken_i;

endmodule

`default_nettype wire

/* build.f */
exec_pkg.sv
exec_alu.sv
branch_unit.sv
lsu_request.sv
result_stage.sv
exec_top.sv
exec_props.sv
tb_exec.sv

/* exec_alu.sv */
/*
 * Integer ALU of the execute stage
 * Operand adder, PC-relative adder, logic and shift results, compare flags
 */

`timescale 1ns/1ps
`default_nettype none

module exec_alu (
    input  exec_pkg::exec_op_e          op_i,
    input  logic [exec_pkg::XLEN-1:0]   pc_i,
    input  logic [exec_pkg::XLEN-1:0]   first_operand_i,
    input  logic [exec_pkg::XLEN-1:0]   second_operand_i,
    input  logic [exec_pkg::XLEN-1:0]   third_operand_i,
    input  logic                        compressed_i,
    output logic [exec_pkg::XLEN-1:0]   sum_o,
    output logic [exec_pkg::XLEN-1:0]   pc_sum_o,
    output logic [exec_pkg::XLEN-1:0]   alu_result_o,
    output logic                        equal_o,
    output logic                        less_o,
    output logic                        less_unsigned_o
);

    import exec_pkg::*;

    logic [XLEN-1:0]    pc_add_a;
    logic [XLEN-1:0]    pc_add_b;
    logic [XLEN-1:0]    link_step;
    logic [SHAMT_W-1:0] shamt;

    ////////////////////////////////////////
    // Adders
    ////////////////////////////////////////

    // Base plus offset, also the load/store address
    assign sum_o = first_operand_i + second_operand_i;

    assign link_step = compressed_i ? LINK_STEP_COMPRESSED : LINK_STEP_FULL;

    // Second adder is shared by SUB, link values and branch targets
    always_comb begin
        unique case (op_i)
            SUB: begin
                pc_add_a = first_operand_i;
                pc_add_b = -second_operand_i;
            end
            JAL, JALR: begin
                pc_add_a = pc_i;
                pc_add_b = link_step;
            end
            default: begin
                pc_add_a = pc_i;
                pc_add_b = third_operand_i;
            end
        endcase
    end

    assign pc_sum_o = pc_add_a + pc_add_b;

    ////////////////////////////////////////
    // Compare and logic
    ////////////////////////////////////////

    assign equal_o         = (first_operand_i == second_operand_i);
    assign less_o          = ($signed(first_operand_i) < $signed(second_operand_i));
    assign less_unsigned_o = (first_operand_i < second_operand_i);

    // Only the low bits count as shift amount
    assign shamt = second_operand_i[SHAMT_W-1:0];

    always_comb begin
        unique case (op_i)
            AND:     alu_result_o = first_operand_i & second_operand_i;
            OR:      alu_result_o = first_operand_i | second_operand_i;
            XOR:     alu_result_o = first_operand_i ^ second_operand_i;
            SLL:     alu_result_o = first_operand_i << shamt;
            SRL:     alu_result_o = first_operand_i >> shamt;
            SRA:     alu_result_o = $unsigned($signed(first_operand_i) >>> shamt);
            SLT:     alu_result_o = {{(XLEN-1){1'b0}}, less_o};
            SLTU:    alu_result_o = {{(XLEN-1){1'b0}}, less_unsigned_o};
            LUI:     alu_result_o = second_operand_i;
            default: alu_result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* exec_pkg.sv */
/*
 * Execute stage shared definitions
 * Word, register index and byte lane widths, link steps, operation codes
 */

`default_nettype none

package exec_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    // One RV32 word, data and address
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    // Byte lanes in a memory word
    localparam int BYTE_EN_W  = XLEN / 8;
    localparam int SHAMT_W    = 5;

    // Return address step for full and compressed instructions
    localparam logic [XLEN-1:0] LINK_STEP_FULL       = XLEN'(4);
    localparam logic [XLEN-1:0] LINK_STEP_COMPRESSED = XLEN'(2);

    ////////////////////////////////////////
    // Operation codes
    ////////////////////////////////////////

    typedef enum logic [4:0] {
        NOP,
        // Arithmetic and logic
        ADD, SUB,
        AND, OR, XOR,
        SLL, SRL, SRA,
        SLT, SLTU,
        LUI,
        // Jumps
        JAL, JALR,
        // Conditional branches
        BEQ, BNE,
        BLT, BLTU,
        BGE, BGEU,
        // Loads
        LB, LBU, LH, LHU, LW,
        // Stores
        SB, SH, SW
    } exec_op_e;

endpackage

`default_nettype wire

/* exec_props.sv */
/*
 * Concurrent assertions on the execute stage outputs, bound to exec_top
 */

`timescale 1ns/1ps
`default_nettype none

module exec_props (
    input logic                             clk,
    input logic                             reset_n,
    input logic                             stall_i,
    input logic                             jump_i,
    input logic                             jump_rollback_i,
    input logic                             mem_read_enable_i,
    input logic [exec_pkg::BYTE_EN_W-1:0]   mem_write_enable_i,
    input logic                             write_enable_i
);

    // A jump and a rollback exclude each other
    jump_or_rollback: assert property (@(posedge clk) disable iff (!reset_n)
        !(jump_i && jump_rollback_i))
        else $error("jump_o and jump_rollback_o high in the same cycle");

    // Loads and stores never overlap
    read_or_write: assert property (@(posedge clk) disable iff (!reset_n)
        !(mem_read_enable_i && (|mem_write_enable_i)))
        else $error("read strobe and byte enables high in the same cycle");

    stall_gives_bubble: assert property (@(posedge clk) disable iff (!reset_n)
        stall_i |=> !write_enable_i)
        else $error("write_enable_o high after a stalled cycle");

endmodule

bind exec_top exec_props props_i (
    .clk                (clk),
    .reset_n            (reset_n),
    .stall_i            (stall_i),
    .jump_i             (jump_o),
    .jump_rollback_i    (jump_rollback_o),
    .mem_read_enable_i  (mem_read_enable_o),
    .mem_write_enable_i (mem_write_enable_o),
    .write_enable_i     (write_enable_o)
);

`default_nettype wire

/* exec_top.sv */
/*
 * Execute stage top level
 * ALU, branch unit, load/store request and result register
 */

`timescale 1ns/1ps
`default_nettype none

module exec_top #(
    parameter bit BRANCH_PREDICT = 1'b1
) (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                stall_i,
    input  exec_pkg::exec_op_e                  op_i,
    input  logic [exec_pkg::XLEN-1:0]           pc_i,
    input  logic [exec_pkg::XLEN-1:0]           first_operand_i,
    input  logic [exec_pkg::XLEN-1:0]           second_operand_i,
    input  logic [exec_pkg::XLEN-1:0]           third_operand_i,
    input  logic [exec_pkg::REG_ADDR_W-1:0]     rd_i,
    input  logic                                compressed_i,
    input  logic                                bp_taken_i,
    output logic                                write_enable_o,
    output exec_pkg::exec_op_e                  op_o,
    output logic [exec_pkg::XLEN-1:0]           result_o,
    output logic [exec_pkg::REG_ADDR_W-1:0]     rd_o,
    output logic [exec_pkg::XLEN-1:0]           mem_address_o,
    output logic                                mem_read_enable_o,
    output logic [exec_pkg::BYTE_EN_W-1:0]      mem_write_enable_o,
    output logic [exec_pkg::XLEN-1:0]           mem_write_data_o,
    output logic                                jump_o,
    output logic                                jump_rollback_o,
    output logic [exec_pkg::XLEN-1:0]           jump_target_o
);

    import exec_pkg::*;

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] pc_sum;
    logic [XLEN-1:0] alu_result;
    logic            equal;
    logic            less;
    logic            less_unsigned;

    ////////////////////////////////////////
    // Combinational front
    ////////////////////////////////////////

    exec_alu alu_i (
        .op_i             (op_i),
        .pc_i             (pc_i),
        .first_operand_i  (first_operand_i),
        .second_operand_i (second_operand_i),
        .third_operand_i  (third_operand_i),
        .compressed_i     (compressed_i),
        .sum_o            (sum),
        .pc_sum_o         (pc_sum),
        .alu_result_o     (alu_result),
        .equal_o          (equal),
        .less_o           (less),
        .less_unsigned_o  (less_unsigned)
    );

    branch_unit #(
        .BRANCH_PREDICT (BRANCH_PREDICT)
    ) branch_i (
        .op_i            (op_i),
        .equal_i         (equal),
        .less_i          (less),
        .less_unsigned_i (less_unsigned),
        .bp_taken_i      (bp_taken_i),
        .sum_i           (sum),
        .pc_sum_i        (pc_sum),
        .jump_o          (jump_o),
        .jump_rollback_o (jump_rollback_o),
        .jump_target_o   (jump_target_o)
    );

    lsu_request lsu_i (
        .op_i               (op_i),
        .sum_i              (sum),
        .third_operand_i    (third_operand_i),
        .mem_address_o      (mem_address_o),
        .mem_read_enable_o  (mem_read_enable_o),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o)
    );

    // Registered towards writeback
    result_stage result_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .stall_i        (stall_i),
        .op_i           (op_i),
        .rd_i           (rd_i),
        .sum_i          (sum),
        .pc_sum_i       (pc_sum),
        .alu_result_i   (alu_result),
        .write_enable_o (write_enable_o),
        .op_o           (op_o),
        .result_o       (result_o),
        .rd_o           (rd_o)
    );

endmodule

`default_nettype wire

/* lsu_request.sv */
/*
 * Load/store request: word address, byte enables,
 * replicated store data and load read strobe
 */

`timescale 1ns/1ps
`default_nettype none

module lsu_request (
    input  exec_pkg::exec_op_e              op_i,
    input  logic [exec_pkg::XLEN-1:0]       sum_i,
    input  logic [exec_pkg::XLEN-1:0]       third_operand_i,
    output logic [exec_pkg::XLEN-1:0]       mem_address_o,
    output logic                            mem_read_enable_o,
    output logic [exec_pkg::BYTE_EN_W-1:0]  mem_write_enable_o,
    output logic [exec_pkg::XLEN-1:0]       mem_write_data_o
);

    import exec_pkg::*;

    logic [1:0] byte_offset;

    assign byte_offset = sum_i[1:0];

    // Memory is addressed by word
    assign mem_address_o = {sum_i[XLEN-1:2], 2'b00};

    assign mem_read_enable_o = op_i inside {LB, LBU, LH, LHU, LW};

    ////////////////////////////////////////
    // Byte lanes
    ////////////////////////////////////////

    always_comb begin
        unique case (op_i)
            SB: begin
                mem_write_enable_o = BYTE_EN_W'(1) << byte_offset;
            end
            SH: begin
                mem_write_enable_o = byte_offset[1] ? 4'b1100 : 4'b0011;
            end
            SW:      mem_write_enable_o = '1;
            default: mem_write_enable_o = '0;
        endcase
    end

    // Data copied to every lane, the enables pick the lanes written
    always_comb begin
        unique case (op_i)
            SB:      mem_write_data_o = {4{third_operand_i[7:0]}};
            SH:      mem_write_data_o = {2{third_operand_i[15:0]}};
            default: mem_write_data_o = third_operand_i;
        endcase
    end

endmodule

`default_nettype wire

/* result_stage.sv */
/*
 * Writeback value selection, write enable decision
 * and the result register with stall bubble
 */

`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                stall_i,
    input  exec_pkg::exec_op_e                  op_i,
    input  logic [exec_pkg::REG_ADDR_W-1:0]     rd_i,
    input  logic [exec_pkg::XLEN-1:0]           sum_i,
    input  logic [exec_pkg::XLEN-1:0]           pc_sum_i,
    input  logic [exec_pkg::XLEN-1:0]           alu_result_i,
    output logic                                write_enable_o,
    output exec_pkg::exec_op_e                  op_o,
    output logic [exec_pkg::XLEN-1:0]           result_o,
    output logic [exec_pkg::REG_ADDR_W-1:0]     rd_o
);

    import exec_pkg::*;

    logic [XLEN-1:0] result;
    logic            write_enable;

    // Loads write their effective address, data comes later
    always_comb begin
        unique case (op_i)
            JAL, JALR, SUB:        result = pc_sum_i;
            AND, OR, XOR,
            SLL, SRL, SRA,
            SLT, SLTU, LUI:        result = alu_result_i;
            default:               result = sum_i;
        endcase
    end

    // No register write for stores and branches
    assign write_enable = !(op_i inside {NOP, SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU});

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            write_enable_o <= 1'b0;
            op_o           <= NOP;
            result_o       <= '0;
            rd_o           <= '0;
        end else if (stall_i) begin
            // Bubble, upstream presents the instruction again
            write_enable_o <= 1'b0;
            op_o           <= NOP;
            result_o       <= '0;
            rd_o           <= '0;
        end else begin
            write_enable_o <= write_enable;
            op_o           <= op_i;
            result_o       <= result;
            rd_o           <= rd_i;
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_exec -f build.f -o tb_exec_sim

./obj_dir/tb_exec_sim 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi

/* tb_exec.sv */
/*
 * Testbench for the execute stage
 * Stimulus table, random ALU vectors, reference rules, result counts
 */

`timescale 1ns/1ps
`default_nettype none

module tb_exec;

    import exec_pkg::*;

    // Flags are {compressed, bp_taken, stall}, expected bits are {write enable, jump, rollback}
    typedef struct packed {
        exec_op_e             op;
        logic [XLEN-1:0]      pc;
        logic [XLEN-1:0]      a;
        logic [XLEN-1:0]      b;
        logic [XLEN-1:0]      c;
        logic [2:0]           flags;
        logic [2:0]           exp;
        logic [XLEN-1:0]      res;
        logic [XLEN-1:0]      tgt;
        logic [BYTE_EN_W-1:0] be;
    } row_t;

    localparam int NUM_TABLE      = 36;
    localparam int NUM_RANDOM     = 64;
    localparam int NUM_ROWS       = NUM_TABLE + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = 2 * NUM_ROWS + 40;

    localparam row_t STIMULUS [NUM_TABLE] = '{
        // ALU, result one cycle later
        '{ADD,  'h1000, 'h5,        'h7,        'h0,        3'b000, 3'b100, 'hc,        'h0, 4'h0},
        '{SUB,  'h1000, 'h10,       'h30,       'h0,        3'b000, 3'b100, 'hffffffe0, 'h0, 4'h0},
        '{AND,  'h1000, 'hf0f000ff, 'h0ff00f0f, 'h0,        3'b000, 3'b100, 'h00f0000f, 'h0, 4'h0},
        '{OR,   'h1000, 'hf0f000ff, 'h0ff00f0f, 'h0,        3'b000, 3'b100, 'hfff00fff, 'h0, 4'h0},
        '{XOR,  'h1000, 'hf0f000ff, 'h0ff00f0f, 'h0,        3'b000, 3'b100, 'hff000ff0, 'h0, 4'h0},
        '{SLL,  'h1000, 'h1,        'h24,       'h0,        3'b000, 3'b100, 'h10,       'h0, 4'h0},
        '{SRL,  'h1000, 'h80000000, 'h3f,       'h0,        3'b000, 3'b100, 'h1,        'h0, 4'h0},
        '{SRA,  'h1000, 'h80000000, 'h4,        'h0,        3'b000, 3'b100, 'hf8000000, 'h0, 4'h0},
        '{SLT,  'h1000, 'hffffffff, 'h1,        'h0,        3'b000, 3'b100, 'h1,        'h0, 4'h0},
        '{SLTU, 'h1000, 'hffffffff, 'h1,        'h0,        3'b000, 3'b100, 'h0,        'h0, 4'h0},
        '{LUI,  'h1000, 'h1234,     'habcde000, 'h0,        3'b000, 3'b100, 'habcde000, 'h0, 4'h0},
        // Branches, target is pc plus offset
        '{BEQ,  'h2000, 'h3,        'h3,        'h40,       3'b000, 3'b010, 'h0, 'h2040, 4'h0},
        '{BNE,  'h2000, 'h3,        'h3,        'h40,       3'b000, 3'b000, 'h0, 'h2040, 4'h0},
        '{BLT,  'h2000, 'hfffffffe, 'h1,        'h40,       3'b000, 3'b010, 'h0, 'h2040, 4'h0},
        '{BLTU, 'h2000, 'hfffffffe, 'h1,        'h40,       3'b000, 3'b000, 'h0, 'h2040, 4'h0},
        '{BGE,  'h2000, 'hfffffffe, 'h1,        'h40,       3'b000, 3'b000, 'h0, 'h2040, 4'h0},
        '{BGEU, 'h2000, 'hfffffffe, 'h1,        'h40,       3'b000, 3'b010, 'h0, 'h2040, 4'h0},
        // Predicted taken
        '{BEQ,  'h2000, 'h3,        'h3,        'h40,       3'b010, 3'b000, 'h0, 'h2040, 4'h0},
        '{BNE,  'h2000, 'h3,        'h3,        'h40,       3'b010, 3'b001, 'h0, 'h2040, 4'h0},
        '{BGEU, 'h2000, 'h1,        'h2,        'h40,       3'b010, 3'b001, 'h0, 'h2040, 4'h0},
        // Jumps and link values
        '{JAL,  'h3000, 'h3000,     'h100,      'h0,        3'b000, 3'b110, 'h3004, 'h3100, 4'h0},
        '{JAL,  'h3000, 'h3000,     'h20,       'h0,        3'b100, 3'b110, 'h3002, 'h3020, 4'h0},
        '{JALR, 'h3000, 'h5001,     'h2,        'h0,        3'b000, 3'b110, 'h3004, 'h5002, 4'h0},
        // Stores at every low address
        '{SB,   'h0,    'h4000,     'h0,        'ha1b2c3d4, 3'b000, 3'b000, 'h0, 'h0, 4'h1},
        '{SB,   'h0,    'h4000,     'h1,        'ha1b2c3d4, 3'b000, 3'b000, 'h0, 'h0, 4'h2},
        '{SB,   'h0,    'h4000,     'h2,        'ha1b2c3d4, 3'b000, 3'b000, 'h0, 'h0, 4'h4},
        '{SB,   'h0,    'h4000,     'h3,        'ha1b2c3d4, 3'b000, 3'b000, 'h0, 'h0, 4'h8},
        '{SH,   'h0,    'h4000,     'h0,        'ha1b2c3d4, 3'b000, 3'b000, 'h0, 'h0, 4'h3},
        '{SH,   'h0,    'h4000,     'h1,        'ha1b2c3d4, 3'b000, 3'b000, 'h0, 'h0, 4'h3},
        '{SH,   'h0,    'h4000,     'h2,        'ha1b2c3d4, 3'b000, 3'b000, 'h0, 'h0, 4'hc},
        '{SH,   'h0,    'h4000,     'h3,        'ha1b2c3d4, 3'b000, 3'b000, 'h0, 'h0, 4'hc},
        '{SW,   'h0,    'h4000,     'h0,        'ha1b2c3d4, 3'b000, 3'b000, 'h0, 'h0, 4'hf},
        // Loads write back their effective address
        '{LW,   'h0,    'h4000,     'h8,        'h0,        3'b000, 3'b100, 'h4008, 'h0, 4'h0},
        '{LB,   'h0,    'h4000,     'h7,        'h0,        3'b000, 3'b100, 'h4007, 'h0, 4'h0},
        // Stalled, then presented again
        '{ADD,  'h1000, 'h5,        'h7,        'h0,        3'b001, 3'b000, 'h0,    'h0, 4'h0},
        '{ADD,  'h1000, 'h5,        'h7,        'h0,        3'b000, 3'b100, 'hc,    'h0, 4'h0}
    };

    logic                  clk = 1'b0;
    logic                  reset_n;
    logic                  stall_i;
    exec_op_e              op_i;
    logic [XLEN-1:0]       pc_i;
    logic [XLEN-1:0]       first_operand_i;
    logic [XLEN-1:0]       second_operand_i;
    logic [XLEN-1:0]       third_operand_i;
    logic [REG_ADDR_W-1:0] rd_i;
    logic                  compressed_i;
    logic                  bp_taken_i;
    logic                  write_enable_o;
    exec_op_e              op_o;
    logic [XLEN-1:0]       result_o;
    logic [REG_ADDR_W-1:0] rd_o;
    logic [XLEN-1:0]       mem_address_o;
    logic                  mem_read_enable_o;
    logic [BYTE_EN_W-1:0]  mem_write_enable_o;
    logic [XLEN-1:0]       mem_write_data_o;
    logic                  jump_o;
    logic                  jump_rollback_o;
    logic [XLEN-1:0]       jump_target_o;

    row_t        rows [NUM_ROWS];
    int          row_err [NUM_ROWS];
    int unsigned cycle_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic [31:0] rnd_state;

    exec_top #(
        .BRANCH_PREDICT (1'b1)
    ) dut_i (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    ////////////////////////////////////////
    // Reference rules
    ////////////////////////////////////////

    function automatic logic [XLEN-1:0] alu_ref(input exec_op_e op,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SRA:     return $unsigned($signed(a) >>> b[4:0]);
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:    return (a < b) ? 32'd1 : 32'd0;
            LUI:     return b;
            default: return '0;
        endcase
    endfunction

    // Narrow stores copy their data to every lane
    function automatic logic [XLEN-1:0] store_data_ref(input exec_op_e op,
                                                       input logic [XLEN-1:0] d);
        case (op)
            SB:      return {4{d[7:0]}};
            SH:      return {2{d[15:0]}};
            default: return d;
        endcase
    endfunction

    function automatic logic [REG_ADDR_W-1:0] rd_of(input int i);
        return REG_ADDR_W'(i % 31 + 1);
    endfunction

    task automatic mismatch(input int i, input string msg);
        $display("ERROR at %0t ns: row %0d %s", $time, i, msg);
        row_err[i]++;
    endtask

    task automatic apply_row(input int i);
        op_i             = rows[i].op;
        pc_i             = rows[i].pc;
        first_operand_i  = rows[i].a;
        second_operand_i = rows[i].b;
        third_operand_i  = rows[i].c;
        compressed_i     = rows[i].flags[2];
        bp_taken_i       = rows[i].flags[1];
        stall_i          = rows[i].flags[0];
        rd_i             = rd_of(i);
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic check_combinational(input int i);
        row_t            r;
        logic [XLEN-1:0] addr;
        r = rows[i];
        addr = (r.a + r.b) & ~32'h3;
        if (jump_o !== r.exp[1])
            mismatch(i, $sformatf("jump_o %b, expected %b", jump_o, r.exp[1]));
        if (jump_rollback_o !== r.exp[0])
            mismatch(i, $sformatf("jump_rollback_o %b, expected %b", jump_rollback_o, r.exp[0]));
        if (r.op inside {JAL, JALR, BEQ, BNE, BLT, BLTU, BGE, BGEU} && jump_target_o !== r.tgt)
            mismatch(i, $sformatf("jump_target_o %h, expected %h", jump_target_o, r.tgt));
        if (mem_read_enable_o !== (r.op inside {LB, LBU, LH, LHU, LW}))
            mismatch(i, $sformatf("mem_read_enable_o %b is wrong", mem_read_enable_o));
        if (mem_write_enable_o !== r.be)
            mismatch(i, $sformatf("mem_write_enable_o %b, expected %b", mem_write_enable_o, r.be));
        if (mem_address_o !== addr)
            mismatch(i, $sformatf("mem_address_o %h, expected %h", mem_address_o, addr));
        if (r.op inside {SB, SH, SW} && mem_write_data_o !== store_data_ref(r.op, r.c))
            mismatch(i, $sformatf("mem_write_data_o %h, expected %h",
                                  mem_write_data_o, store_data_ref(r.op, r.c)));
    endtask

    // Registered outputs, one edge after the row was presented
    task automatic check_registered(input int i);
        row_t     r;
        exec_op_e op;
        logic     stalled;
        r = rows[i];
        op = r.op;
        stalled = r.flags[0];
        if (write_enable_o !== r.exp[2])
            mismatch(i, $sformatf("write_enable_o %b, expected %b", write_enable_o, r.exp[2]));
        if (op_o !== (stalled ? NOP : op))
            mismatch(i, $sformatf("op_o %s is wrong", op_o.name()));
        if ((r.exp[2] || stalled) && result_o !== r.res)
            mismatch(i, $sformatf("result_o %h, expected %h", result_o, r.res));
        if (rd_o !== (stalled ? 5'd0 : rd_of(i)))
            mismatch(i, $sformatf("rd_o %0d is wrong", rd_o));
        tests_run++;
        if (row_err[i] == 0) begin
            $display("row %0d %s: ok", i, op.name());
        end else begin
            tests_failed++;
            $display("row %0d %s: failed with %0d errors", i, op.name(), row_err[i]);
        end
    endtask

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        reset_n          = 1'b0;
        stall_i          = 1'b0;
        op_i             = NOP;
        pc_i             = '0;
        first_operand_i  = '0;
        second_operand_i = '0;
        third_operand_i  = '0;
        rd_i             = '0;
        compressed_i     = 1'b0;
        bp_taken_i       = 1'b0;

        for (int i = 0; i < NUM_TABLE; i++)
            rows[i] = STIMULUS[i];
        // Random ALU vectors after the table
        rnd_state = 32'd85;
        for (int i = NUM_TABLE; i < NUM_ROWS; i++) begin
            rnd_state = xorshift(rnd_state);
            rows[i].op = exec_op_e'(5'(int'(ADD) + int'(rnd_state % 11)));
            rnd_state = xorshift(rnd_state);
            rows[i].a = rnd_state;
            rnd_state = xorshift(rnd_state);
            rows[i].b = rnd_state;
            rows[i].pc = 'h1000;
            rows[i].c = '0;
            rows[i].flags = 3'b000;
            rows[i].exp = 3'b100;
            rows[i].res = alu_ref(rows[i].op, rows[i].a, rows[i].b);
            rows[i].tgt = '0;
            rows[i].be = '0;
        end
        for (int i = 0; i < NUM_ROWS; i++)
            row_err[i] = 0;

        repeat (5) @(negedge clk);
        reset_n = 1'b1;
        tests_run++;
        if (write_enable_o !== 1'b0 || op_o !== NOP || result_o !== '0) begin
            $display("ERROR at %0t ns: after reset write_enable_o %b op_o %s result_o %h",
                     $time, write_enable_o, op_o.name(), result_o);
            tests_failed++;
            $display("reset: failed");
        end else begin
            $display("reset: ok");
        end

        for (int i = 0; i < NUM_ROWS; i++) begin
            @(negedge clk);
            if (i > 0)
                check_registered(i - 1);
            apply_row(i);
            #10;
            check_combinational(i);
        end
        @(negedge clk);
        check_registered(NUM_ROWS - 1);

        $display("Tests: %0d run, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
